//--- tb.f
+incdir+include
source/ooo_pkg.sv
source/mult_pipe.sv
source/exec_stage.sv
source/inst_decode.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/ooo_core.sv
dv/ooo_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Verification failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Override: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int PERIOD      = 40;
  localparam int TOTAL_INSTS = 64;  // Upper bound over all programs
  localparam int WATCHDOG_NS = TOTAL_INSTS * (`MUL_STAGES + 4) * PERIOD + 200 * PERIOD;

  logic             clock;
  logic             rst;
  logic [31:0]      inst;
  logic             inst_valid;
  logic             dispatch_ready;
  reg_idx_t         commit_wr_idx;
  logic [`XLEN-1:0] commit_wr_data;
  logic             commit_wr_en;
  logic             completed_insts;
  error_code_t      error_status;
  logic             stop_cycle;

  logic [`XLEN-1:0] model_regs [`NUM_ARCH_REG];
  error_code_t      model_status;
  bit               exp_wen  [$];  // Expected commits, program order
  logic [4:0]       exp_idx  [$];
  logic [`XLEN-1:0] exp_data [$];
  logic [31:0]      lfsr_state;
  int value_errs, other_errs, sent_count, commit_count, stall_cycles;

  ooo_core dut_i (
    .clock (clock), .rst (rst), .inst (inst), .inst_valid (inst_valid),
    .dispatch_ready (dispatch_ready), .commit_wr_idx (commit_wr_idx),
    .commit_wr_data (commit_wr_data), .commit_wr_en (commit_wr_en),
    .completed_insts (completed_insts), .error_status (error_status),
    .stop_cycle (stop_cycle)
  );

  always #(PERIOD/2) clock = ~clock;

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[6:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] reg_form(input logic [5:0] opc, input logic [6:0] fn,
                                           input logic [4:0] ra, input logic [4:0] rb,
                                           input logic [4:0] rc);
    return {opc, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  function automatic logic [31:0] lit_form(input logic [5:0] opc, input logic [6:0] fn,
                                           input logic [4:0] ra, input logic [7:0] lit,
                                           input logic [4:0] rc);
    return {opc, ra, lit, 1'b1, fn, rc};
  endfunction

  function automatic logic [`XLEN-1:0] model_read(input logic [4:0] r);
    return (r == 5'd31) ? '0 : model_regs[r];
  endfunction

  // Reference model of one operate-format word
  task automatic predict(input logic [31:0] w, output bit wen,
                         output logic [`XLEN-1:0] val, output error_code_t kind);
    logic [`XLEN-1:0] a, b;
    logic [12:0]      key;
    a    = model_read(w[25:21]);
    b    = w[12] ? {{(`XLEN-8){1'b0}}, w[20:13]} : model_read(w[20:16]);
    key  = {w[31:26], w[11:5]};
    val  = '0;
    kind = no_error;
    if (w == 32'h0) kind = halted_on_halt;
    else if (key == {6'h10, 7'h20}) val = a + b;
    else if (key == {6'h10, 7'h29}) val = a - b;
    else if (key == {6'h10, 7'h2d}) val = (a == b) ? 1 : 0;
    else if (key == {6'h11, 7'h00}) val = a & b;
    else if (key == {6'h11, 7'h20}) val = a | b;
    else if (key == {6'h11, 7'h40}) val = a ^ b;
    else if (key == {6'h13, 7'h20}) val = a * b;
    else kind = halted_on_illegal;
    wen = (kind == no_error) && (w[4:0] != 5'd31);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Starts and ends on a falling edge, holds the word until taken or max_wait
  task automatic offer_inst(input logic [31:0] w, input int max_wait, output bit taken);
    int               waited;
    bit               wen;
    logic [`XLEN-1:0] val;
    error_code_t      kind;
    waited     = 0;
    inst       = w;
    inst_valid = 1'b1;
    #1;
    while (!dispatch_ready && waited < max_wait) begin
      stall_cycles++;
      waited++;
      @(negedge clock);
      #1;
    end
    taken = dispatch_ready;
    if (taken) begin
      predict(w, wen, val, kind);
      exp_wen.push_back(wen);
      exp_idx.push_back(w[4:0]);
      exp_data.push_back(val);
      if (wen) model_regs[w[4:0]] = val;
      if (kind != no_error) model_status = kind;
      sent_count++;
    end
    @(negedge clock);
    inst_valid = 1'b0;
  endtask

  task automatic send_inst(input logic [31:0] w);
    bit taken;
    offer_inst(w, 64, taken);
    assert (taken) else begin
      other_errs++;
      $display("Instruction %h was never accepted", w);
    end
  endtask

  task automatic start_test(input string name);
    $display("Running %s", name);
    @(negedge clock);
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (4) @(negedge clock);
    rst = 1'b0;
    for (int i = 0; i < `NUM_ARCH_REG; i++) model_regs[i] = '0;
    model_status = no_error;
    exp_wen.delete();
    exp_idx.delete();
    exp_data.delete();
    sent_count   = 0;
    commit_count = 0;
    stall_cycles = 0;
  endtask

  task automatic finish_test();
    inst_valid = 1'b0;
    while (exp_wen.size() > 0) @(negedge clock);
    repeat (`MUL_STAGES + 4) @(negedge clock);  // Room for stray commits
    assert (commit_count == sent_count) else begin
      other_errs++;
      $display("%0d instructions completed but %0d were sent", commit_count, sent_count);
    end
    check_value("error_status", error_status, model_status);
    check_value("stop_cycle", stop_cycle, model_status != no_error);
  endtask

  // Commit outputs only move on the rising edge
  always @(negedge clock) begin
    if (!rst && completed_insts) begin
      commit_count++;
      assert (exp_wen.size() > 0) else begin
        other_errs++;
        $display("An instruction committed with none outstanding");
      end
      if (exp_wen.size() > 0) begin
        check_value("commit_wr_en", commit_wr_en, exp_wen[0]);
        if (exp_wen[0]) begin
          check_value("commit_wr_idx", commit_wr_idx, exp_idx[0]);
          check_value("commit_wr_data", commit_wr_data, exp_data[0]);
        end
        void'(exp_wen.pop_front());
        void'(exp_idx.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  task automatic alu_ops();
    logic [5:0] opc [6];
    logic [6:0] fn  [6];
    opc = '{op_inta, op_inta, op_inta, op_intl, op_intl, op_intl};
    fn  = '{fn_add, fn_sub, fn_cmpeq, fn_and, fn_bis, fn_xor};
    start_test("ALU operations");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd1));
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd2));
    for (int i = 0; i < 6; i++) begin
      send_inst(reg_form(opc[i], fn[i], 5'd1, 5'd2, 5'(3 + i)));
      send_inst(lit_form(opc[i], fn[i], 5'd2, rand_byte(), 5'(10 + i)));
    end
    // cmpeq on equal operands
    send_inst(reg_form(op_inta, fn_cmpeq, 5'd1, 5'd1, 5'd20));
    send_inst(lit_form(op_inta, fn_cmpeq, 5'd2, model_regs[2][7:0], 5'd21));
    finish_test();
  endtask

  task automatic dependency_chains();
    start_test("dependency chains");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte() | 8'h01, 5'd1));
    send_inst(lit_form(op_inta, fn_add, 5'd1, rand_byte(), 5'd2));
    send_inst(reg_form(op_intm, fn_mul, 5'd2, 5'd1, 5'd3));
    send_inst(reg_form(op_inta, fn_sub, 5'd3, 5'd2, 5'd4));
    send_inst(reg_form(op_intm, fn_mul, 5'd4, 5'd4, 5'd5));
    send_inst(reg_form(op_intl, fn_xor, 5'd5, 5'd3, 5'd6));
    send_inst(reg_form(op_inta, fn_add, 5'd6, 5'd6, 5'd6));  // Same reg in and out
    send_inst(lit_form(op_intm, fn_mul, 5'd6, rand_byte(), 5'd7));
    send_inst(reg_form(op_inta, fn_cmpeq, 5'd7, 5'd7, 5'd8));
    finish_test();
  endtask

  task automatic mul_then_alu_order();
    start_test("multiply ahead of ALU work");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd1));
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd2));
    send_inst(reg_form(op_intm, fn_mul, 5'd1, 5'd2, 5'd3));
    send_inst(lit_form(op_inta, fn_add, 5'd1, rand_byte(), 5'd4));
    send_inst(lit_form(op_intl, fn_xor, 5'd2, rand_byte(), 5'd5));
    send_inst(reg_form(op_inta, fn_sub, 5'd1, 5'd2, 5'd6));
    send_inst(lit_form(op_intl, fn_and, 5'd2, rand_byte(), 5'd7));
    finish_test();
  endtask

  task automatic zero_reg_use();
    start_test("R31 reads and writes");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd1));
    send_inst(lit_form(op_inta, fn_add, 5'd1, rand_byte(), 5'd31));
    send_inst(reg_form(op_intm, fn_mul, 5'd1, 5'd1, 5'd31));
    send_inst(lit_form(op_inta, fn_add, 5'd31, rand_byte(), 5'd5));
    send_inst(reg_form(op_intl, fn_bis, 5'd31, 5'd31, 5'd6));
    send_inst(reg_form(op_inta, fn_sub, 5'd1, 5'd31, 5'd7));
    finish_test();
  endtask

  task automatic mul_burst();
    start_test("multiply burst");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd1));
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd2));
    for (int i = 0; i < 10; i++) begin
      if (i % 2 == 0) send_inst(lit_form(op_intm, fn_mul, 5'd2, rand_byte(), 5'(3 + i)));
      else            send_inst(reg_form(op_intm, fn_mul, 5'd1, 5'd2, 5'(3 + i)));
    end
    assert (stall_cycles > 0) else begin
      other_errs++;
      $display("dispatch_ready never dropped during the multiply burst");
    end
    finish_test();
  endtask

  task automatic halt_and_illegal();
    bit taken;
    start_test("halt");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd1));
    send_inst(reg_form(op_intm, fn_mul, 5'd1, 5'd1, 5'd2));
    send_inst(32'h0);
    for (int i = 0; i < 2; i++) begin
      offer_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'(3 + i)), 6, taken);
      assert (!taken) else begin
        other_errs++;
        $display("An instruction was accepted after a halt");
      end
    end
    finish_test();
    start_test("illegal instruction");
    send_inst(lit_form(op_intl, fn_bis, 5'd31, rand_byte(), 5'd1));
    send_inst(reg_form(op_intm, fn_mul, 5'd1, 5'd1, 5'd2));
    send_inst(reg_form(op_inta, fn_add, 5'd2, 5'd1, 5'd3));
    send_inst(reg_form(op_inta, 7'h7f, 5'd1, 5'd2, 5'd4));  // Unknown function code
    finish_test();
  endtask

  initial begin
    clock      = 1'b0;
    rst        = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    lfsr_state = 32'ha48eb91b;
    value_errs = 0;
    other_errs = 0;
    alu_ops();
    dependency_chains();
    mul_then_alu_order();
    zero_reg_use();
    mul_burst();
    halt_and_illegal();
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    other_errs++;
    $display("Run timed out before all tests finished");
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- source/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module ooo_core (
  input                            clock,
  input                            rst,
  input        [31:0]              inst,
  input                            inst_valid,
  output logic                     dispatch_ready,
  output ooo_pkg::reg_idx_t        commit_wr_idx,
  output logic [`XLEN-1:0]         commit_wr_data,
  output logic                     commit_wr_en,
  output logic                     completed_insts,
  output ooo_pkg::error_code_t     error_status,
  output logic                     stop_cycle
);
  import ooo_pkg::*;

  logic             rob_full;
  rob_tag_t         rob_tail;
  rob_tag_t         lookup_tag_a, lookup_tag_b;
  logic             lookup_done_a, lookup_done_b;
  logic [`XLEN-1:0] lookup_val_a, lookup_val_b;
  reg_idx_t         rf_idx_a, rf_idx_b;
  logic [`XLEN-1:0] rf_val_a, rf_val_b;
  logic             retire_en;
  reg_idx_t         retire_dest;
  rob_tag_t         retire_tag;
  logic [`XLEN-1:0] retire_val;
  logic             alloc;
  reg_idx_t         alloc_dest;
  exec_unit_t       alloc_unit;
  error_code_t      alloc_kind;
  logic             iss_valid;
  alu_op_t          iss_op;
  exec_unit_t       iss_unit;
  logic [`XLEN-1:0] iss_a, iss_b;
  rob_tag_t         iss_tag;
  logic             alu_done, mul_done;
  rob_tag_t         alu_tag, mul_tag;
  logic [`XLEN-1:0] alu_val, mul_val;

  assign commit_wr_idx   = retire_dest;
  assign commit_wr_data  = retire_val;
  assign commit_wr_en    = retire_en && (retire_dest != reg_idx_t'(`ZERO_REG));
  assign completed_insts = retire_en;

  inst_decode decode_i (
    .clock (clock), .rst (rst), .inst (inst), .inst_valid (inst_valid),
    .dispatch_ready (dispatch_ready), .rob_full (rob_full), .rob_tail (rob_tail),
    .lookup_tag_a (lookup_tag_a), .lookup_tag_b (lookup_tag_b),
    .lookup_done_a (lookup_done_a), .lookup_done_b (lookup_done_b),
    .lookup_val_a (lookup_val_a), .lookup_val_b (lookup_val_b),
    .rf_idx_a (rf_idx_a), .rf_idx_b (rf_idx_b), .rf_val_a (rf_val_a), .rf_val_b (rf_val_b),
    .retire_en (retire_en), .retire_dest (retire_dest), .retire_tag (retire_tag),
    .alloc (alloc), .alloc_dest (alloc_dest), .alloc_unit (alloc_unit),
    .alloc_kind (alloc_kind), .iss_valid (iss_valid), .iss_op (iss_op),
    .iss_unit (iss_unit), .iss_a (iss_a), .iss_b (iss_b), .iss_tag (iss_tag)
  );

  exec_stage exec_i (
    .clock (clock), .rst (rst), .iss_valid (iss_valid), .iss_op (iss_op),
    .iss_unit (iss_unit), .iss_a (iss_a), .iss_b (iss_b), .iss_tag (iss_tag),
    .alu_done (alu_done), .alu_tag (alu_tag), .alu_val (alu_val),
    .mul_done (mul_done), .mul_tag (mul_tag), .mul_val (mul_val)
  );

  reorder_buffer rob_i (
    .clock (clock), .rst (rst), .alloc (alloc), .alloc_dest (alloc_dest),
    .alloc_unit (alloc_unit), .alloc_kind (alloc_kind), .full (rob_full), .tail (rob_tail),
    .alu_done (alu_done), .alu_tag (alu_tag), .alu_val (alu_val),
    .mul_done (mul_done), .mul_tag (mul_tag), .mul_val (mul_val),
    .lookup_tag_a (lookup_tag_a), .lookup_tag_b (lookup_tag_b),
    .lookup_done_a (lookup_done_a), .lookup_val_a (lookup_val_a),
    .lookup_done_b (lookup_done_b), .lookup_val_b (lookup_val_b),
    .retire_en (retire_en), .retire_dest (retire_dest), .retire_tag (retire_tag),
    .retire_val (retire_val), .error_status (error_status), .stop_cycle (stop_cycle)
  );

  arch_regfile regfile_i (
    .clock (clock), .rst (rst),
    .rd_idx_a (rf_idx_a), .rd_idx_b (rf_idx_b), .rd_val_a (rf_val_a), .rd_val_b (rf_val_b),
    .wr_en (retire_en), .wr_idx (retire_dest), .wr_val (retire_val)
  );

endmodule

//--- source/arch_regfile.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module arch_regfile (
  input                        clock,
  input                        rst,
  input  ooo_pkg::reg_idx_t    rd_idx_a,
  input  ooo_pkg::reg_idx_t    rd_idx_b,
  output logic [`XLEN-1:0]     rd_val_a,
  output logic [`XLEN-1:0]     rd_val_b,
  input                        wr_en,
  input  ooo_pkg::reg_idx_t    wr_idx,
  input        [`XLEN-1:0]     wr_val
);

  logic [`XLEN-1:0] regs [`NUM_ARCH_REG];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < `NUM_ARCH_REG; i++) regs[i] <= '0;
    end else if (wr_en && wr_idx != `ZERO_REG) begin
      regs[wr_idx] <= wr_val;
    end
  end

  // R31 is hardwired zero
  assign rd_val_a = (rd_idx_a == `ZERO_REG) ? '0 : regs[rd_idx_a];
  assign rd_val_b = (rd_idx_b == `ZERO_REG) ? '0 : regs[rd_idx_b];

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reorder_buffer (
  input                              clock,
  input                              rst,
  input                              alloc,
  input  ooo_pkg::reg_idx_t          alloc_dest,
  input  ooo_pkg::exec_unit_t        alloc_unit,
  input  ooo_pkg::error_code_t       alloc_kind,
  output logic                       full,
  output ooo_pkg::rob_tag_t          tail,
  input                              alu_done,
  input  ooo_pkg::rob_tag_t          alu_tag,
  input        [`XLEN-1:0]           alu_val,
  input                              mul_done,
  input  ooo_pkg::rob_tag_t          mul_tag,
  input        [`XLEN-1:0]           mul_val,
  input  ooo_pkg::rob_tag_t          lookup_tag_a,
  input  ooo_pkg::rob_tag_t          lookup_tag_b,
  output logic                       lookup_done_a,
  output logic [`XLEN-1:0]           lookup_val_a,
  output logic                       lookup_done_b,
  output logic [`XLEN-1:0]           lookup_val_b,
  output logic                       retire_en,
  output ooo_pkg::reg_idx_t          retire_dest,
  output ooo_pkg::rob_tag_t          retire_tag,
  output logic [`XLEN-1:0]           retire_val,
  output ooo_pkg::error_code_t       error_status,
  output logic                       stop_cycle
);
  import ooo_pkg::*;

  logic [`NUM_ROB-1:0]     done_q;
  logic [`XLEN-1:0]        val_q  [`NUM_ROB];
  reg_idx_t                dest_q [`NUM_ROB];
  error_code_t             kind_q [`NUM_ROB];
  rob_tag_t                head;
  logic [$clog2(`NUM_ROB):0] count;

  assign full = (count == `NUM_ROB);

  // Operand lookup for decode
  assign lookup_done_a = done_q[lookup_tag_a];
  assign lookup_val_a  = val_q[lookup_tag_a];
  assign lookup_done_b = done_q[lookup_tag_b];
  assign lookup_val_b  = val_q[lookup_tag_b];

  // In-order retire, frozen once a halt or illegal has gone out
  assign retire_en   = (count != '0) && done_q[head] && !stop_cycle;
  assign retire_dest = dest_q[head];
  assign retire_tag  = head;
  assign retire_val  = val_q[head];

  always_ff @(posedge clock) begin
    if (rst) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      done_q       <= '0;
      error_status <= no_error;
      stop_cycle   <= 1'b0;
    end else begin
      if (alloc) begin
        done_q[tail] <= (alloc_unit == unit_none);  // Halt/illegal are born complete
        tail         <= tail + 1'b1;
      end
      if (alu_done) done_q[alu_tag] <= 1'b1;
      if (mul_done) done_q[mul_tag] <= 1'b1;
      if (retire_en) begin
        head <= head + 1'b1;
        if (kind_q[head] != no_error) begin
          error_status <= kind_q[head];
          stop_cycle   <= 1'b1;
        end
      end
      case ({alloc, retire_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      dest_q[tail] <= alloc_dest;
      kind_q[tail] <= alloc_kind;
      val_q[tail]  <= '0;
    end
    if (alu_done) val_q[alu_tag] <= alu_val;
    if (mul_done) val_q[mul_tag] <= mul_val;
  end

endmodule

//--- source/inst_decode.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module inst_decode (
  input                              clock,
  input                              rst,
  input        [31:0]                inst,
  input                              inst_valid,
  output logic                       dispatch_ready,
  input                              rob_full,
  input  ooo_pkg::rob_tag_t          rob_tail,
  output ooo_pkg::rob_tag_t          lookup_tag_a,
  output ooo_pkg::rob_tag_t          lookup_tag_b,
  input                              lookup_done_a,
  input                              lookup_done_b,
  input        [`XLEN-1:0]           lookup_val_a,
  input        [`XLEN-1:0]           lookup_val_b,
  output ooo_pkg::reg_idx_t          rf_idx_a,
  output ooo_pkg::reg_idx_t          rf_idx_b,
  input        [`XLEN-1:0]           rf_val_a,
  input        [`XLEN-1:0]           rf_val_b,
  input                              retire_en,
  input  ooo_pkg::reg_idx_t          retire_dest,
  input  ooo_pkg::rob_tag_t          retire_tag,
  output logic                       alloc,
  output ooo_pkg::reg_idx_t          alloc_dest,
  output ooo_pkg::exec_unit_t        alloc_unit,
  output ooo_pkg::error_code_t       alloc_kind,
  output logic                       iss_valid,
  output ooo_pkg::alu_op_t           iss_op,
  output ooo_pkg::exec_unit_t        iss_unit,
  output logic [`XLEN-1:0]           iss_a,
  output logic [`XLEN-1:0]           iss_b,
  output ooo_pkg::rob_tag_t          iss_tag
);
  import ooo_pkg::*;

  logic [`NUM_ARCH_REG-1:0] map_busy;
  rob_tag_t                 map_tag [`NUM_ARCH_REG];
  logic                     halt_seen;  // Sticky after halt or illegal

  logic [5:0]  opcode;
  logic [6:0]  func;
  reg_idx_t    src_a, src_b, dest;
  logic        use_lit, need_a, need_b, ready_a, ready_b;
  logic        writes_reg, fire;
  alu_op_t     op;
  exec_unit_t  unit;
  error_code_t kind;

  assign opcode  = inst[31:26];
  assign func    = inst[11:5];
  assign src_a   = inst[25:21];
  assign src_b   = inst[20:16];
  assign dest    = inst[4:0];
  assign use_lit = inst[12];

  always_comb begin
    op   = alu_add;
    unit = unit_none;
    kind = halted_on_illegal;
    case (opcode)
      op_inta: begin
        unit = unit_alu;
        case (func)
          fn_add:   op = alu_add;
          fn_sub:   op = alu_sub;
          fn_cmpeq: op = alu_cmpeq;
          default:  unit = unit_none;
        endcase
      end
      op_intl: begin
        unit = unit_alu;
        case (func)
          fn_and:  op = alu_and;
          fn_bis:  op = alu_bis;
          fn_xor:  op = alu_xor;
          default: unit = unit_none;
        endcase
      end
      op_intm: begin
        unit = unit_mul;
        op   = alu_mul;
        if (func != fn_mul) unit = unit_none;
      end
      default: unit = unit_none;
    endcase
    if (unit != unit_none) kind = no_error;
    else if (opcode == op_pal && inst[25:0] == '0) kind = halted_on_halt;
  end

  // Operand sources, ROB when the producer is in flight
  assign rf_idx_a     = src_a;
  assign rf_idx_b     = src_b;
  assign lookup_tag_a = map_tag[src_a];
  assign lookup_tag_b = map_tag[src_b];

  assign need_a  = (kind == no_error);
  assign need_b  = (kind == no_error) && !use_lit;
  assign ready_a = !need_a || !map_busy[src_a] || lookup_done_a;
  assign ready_b = !need_b || !map_busy[src_b] || lookup_done_b;

  assign dispatch_ready = !rob_full && !halt_seen && ready_a && ready_b;
  assign fire           = inst_valid && dispatch_ready;
  assign writes_reg     = (kind == no_error) && (dest != reg_idx_t'(`ZERO_REG));

  assign alloc      = fire;
  assign alloc_dest = (kind == no_error) ? dest : reg_idx_t'(`ZERO_REG);
  assign alloc_unit = unit;
  assign alloc_kind = kind;

  assign iss_valid = fire && (unit != unit_none);
  assign iss_op    = op;
  assign iss_unit  = unit;
  assign iss_tag   = rob_tail;
  assign iss_a     = map_busy[src_a] ? lookup_val_a : rf_val_a;
  assign iss_b     = use_lit ? {{(`XLEN-8){1'b0}}, inst[20:13]} :
                     map_busy[src_b] ? lookup_val_b : rf_val_b;

  always_ff @(posedge clock) begin
    if (rst) begin
      map_busy  <= '0;
      halt_seen <= 1'b0;
    end else begin
      // Only the newest producer clears its register
      if (retire_en && map_tag[retire_dest] == retire_tag)
        map_busy[retire_dest] <= 1'b0;
      if (fire && writes_reg) map_busy[dest] <= 1'b1;  // Dispatch wins
      if (fire && kind != no_error) halt_seen <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fire && writes_reg) map_tag[dest] <= rob_tail;
  end

endmodule

//--- source/exec_stage.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module exec_stage (
  input                          clock,
  input                          rst,
  input                          iss_valid,
  input  ooo_pkg::alu_op_t       iss_op,
  input  ooo_pkg::exec_unit_t    iss_unit,
  input        [`XLEN-1:0]       iss_a,
  input        [`XLEN-1:0]       iss_b,
  input  ooo_pkg::rob_tag_t      iss_tag,
  output logic                   alu_done,
  output ooo_pkg::rob_tag_t      alu_tag,
  output logic [`XLEN-1:0]       alu_val,
  output logic                   mul_done,
  output ooo_pkg::rob_tag_t      mul_tag,
  output logic [`XLEN-1:0]       mul_val
);
  import ooo_pkg::*;

  logic [`XLEN-1:0] alu_res;
  logic             mul_start;

  always_comb begin
    case (iss_op)
      alu_add:   alu_res = iss_a + iss_b;
      alu_sub:   alu_res = iss_a - iss_b;
      alu_cmpeq: alu_res = {{(`XLEN-1){1'b0}}, iss_a == iss_b};
      alu_and:   alu_res = iss_a & iss_b;
      alu_bis:   alu_res = iss_a | iss_b;
      alu_xor:   alu_res = iss_a ^ iss_b;
      default:   alu_res = '0;  // Multiplies go to mult_pipe
    endcase
  end

  // Result register, completes in the ROB one edge later
  always_ff @(posedge clock) begin
    if (rst) alu_done <= 1'b0;
    else     alu_done <= iss_valid && (iss_unit == unit_alu);
  end

  always_ff @(posedge clock) begin
    alu_tag <= iss_tag;
    alu_val <= alu_res;
  end

  assign mul_start = iss_valid && (iss_unit == unit_mul);

  mult_pipe mult_i (
    .clock    (clock),
    .rst      (rst),
    .start    (mul_start),
    .a        (iss_a),
    .b        (iss_b),
    .tag      (iss_tag),
    .done     (mul_done),
    .done_tag (mul_tag),
    .product  (mul_val)
  );

endmodule

//--- source/mult_pipe.sv
`timescale 1ns/1ps
`include "ooo_settings.svh"

module mult_pipe (
  input                        clock,
  input                        rst,
  input                        start,
  input        [`XLEN-1:0]     a,
  input        [`XLEN-1:0]     b,
  input  ooo_pkg::rob_tag_t    tag,
  output logic                 done,
  output ooo_pkg::rob_tag_t    done_tag,
  output logic [`XLEN-1:0]     product
);
  import ooo_pkg::*;

  localparam int CHUNK = `XLEN / `MUL_STAGES;  // Multiplier bits per stage
  localparam logic [`XLEN-1:0] CHUNK_MASK = {{(`XLEN-CHUNK){1'b0}}, {CHUNK{1'b1}}};

  logic [`MUL_STAGES-1:0] vld;
  rob_tag_t               tag_q [`MUL_STAGES];
  logic [`XLEN-1:0]       a_q   [`MUL_STAGES-1];
  logic [`XLEN-1:0]       b_q   [`MUL_STAGES-1];
  logic [`XLEN-1:0]       sum_q [`MUL_STAGES];  // Running low half of the product

  // a times chunk s of b, shifted into place
  function automatic logic [`XLEN-1:0] partial(input logic [`XLEN-1:0] x,
                                               input logic [`XLEN-1:0] y,
                                               input int s);
    logic [`XLEN-1:0] chunk;
    chunk = (y >> (s * CHUNK)) & CHUNK_MASK;
    return (x * chunk) << (s * CHUNK);
  endfunction

  always_ff @(posedge clock) begin
    if (rst) begin
      vld <= '0;
    end else begin
      vld[0] <= start;
      for (int s = 1; s < `MUL_STAGES; s++) vld[s] <= vld[s-1];
    end
  end

  always_ff @(posedge clock) begin
    tag_q[0] <= tag;
    a_q[0]   <= a;
    b_q[0]   <= b;
    sum_q[0] <= partial(a, b, 0);
    for (int s = 1; s < `MUL_STAGES; s++) begin
      tag_q[s] <= tag_q[s-1];
      sum_q[s] <= sum_q[s-1] + partial(a_q[s-1], b_q[s-1], s);
    end
    for (int s = 1; s < `MUL_STAGES - 1; s++) begin
      a_q[s] <= a_q[s-1];
      b_q[s] <= b_q[s-1];
    end
  end

  assign done     = vld[`MUL_STAGES-1];
  assign done_tag = tag_q[`MUL_STAGES-1];
  assign product  = sum_q[`MUL_STAGES-1];

endmodule

//--- source/ooo_pkg.sv
`include "ooo_settings.svh"

package ooo_pkg;

  typedef logic [$clog2(`NUM_ROB)-1:0] rob_tag_t;
  typedef logic [$clog2(`NUM_ARCH_REG)-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_cmpeq,
    alu_and,
    alu_bis,
    alu_xor,
    alu_mul
  } alu_op_t;

  typedef enum logic [1:0] {
    unit_none, // Halt or illegal, nothing to execute
    unit_alu,
    unit_mul
  } exec_unit_t;

  typedef enum logic [1:0] {
    no_error,
    halted_on_halt,
    halted_on_illegal
  } error_code_t;

  // Operate format opcodes
  localparam logic [5:0] op_pal  = 6'h00;
  localparam logic [5:0] op_inta = 6'h10;
  localparam logic [5:0] op_intl = 6'h11;
  localparam logic [5:0] op_intm = 6'h13;

  // Function codes, bits 11:5
  localparam logic [6:0] fn_add   = 7'h20; // op_inta
  localparam logic [6:0] fn_sub   = 7'h29;
  localparam logic [6:0] fn_cmpeq = 7'h2d;
  localparam logic [6:0] fn_and   = 7'h00; // op_intl
  localparam logic [6:0] fn_bis   = 7'h20;
  localparam logic [6:0] fn_xor   = 7'h40;
  localparam logic [6:0] fn_mul   = 7'h20; // op_intm

endpackage

//--- include/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Datapath width
`define XLEN 64

// Reorder buffer entries, power of two
`define NUM_ROB 8

// Multiplier latency in cycles, divides XLEN
`define MUL_STAGES 4

`define NUM_ARCH_REG 32
`define ZERO_REG 31

`endif
